/* common/vec_add_params.svh */
// lane count is fixed at compile time; the field widths describe binary64 and are not meant to change
`ifndef VEC_ADD_PARAMS_SVH
`define VEC_ADD_PARAMS_SVH

// number of adder lanes working side by side
`define VEC_LANES 4

// binary64 field widths
`define FP_EXP_W 11
`define FP_FRAC_W 52

`endif

/* common/vec_add_pkg.sv */
// shared types only; all sizes follow the macros in vec_add_params.svh
`default_nettype none

`include "vec_add_params.svh"

package vec_add_pkg;

    // IEEE-754 binary64 fields, sign at the top
    typedef struct packed {
        logic                  sign;
        logic [`FP_EXP_W-1:0]  exp;
        logic [`FP_FRAC_W-1:0] frac;
    } fp64_fields_t;

    // the same word seen as raw bits or as its fields
    typedef union packed {
        logic [`FP_EXP_W+`FP_FRAC_W:0] raw;
        fp64_fields_t                  f;
    } fp64_t;

    // one operand or result per lane, lane 0 in the low word
    typedef fp64_t [`VEC_LANES-1:0] fp_vec_t;

    // one handshake bit per lane
    typedef logic [`VEC_LANES-1:0] lane_mask_t;

endpackage

`default_nettype wire

/* double_adder/double_adder.sv */
// normal numbers and zeros only; subnormals flush to signed zero, round to nearest even, no NaN handling
`default_nettype none

`include "vec_add_params.svh"

module double_adder
    import vec_add_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire fp64_t input_a,
    input  wire fp64_t input_b,
    input  wire logic  input_a_stb,
    input  wire logic  input_b_stb,
    output logic       input_a_ack,
    output logic       input_b_ack,
    output fp64_t      output_z,
    output logic       output_z_stb,
    input  wire logic  output_z_ack
);

    localparam int EW = `FP_EXP_W;
    localparam int FW = `FP_FRAC_W;
    // hidden bit, fraction, then guard, round and sticky
    localparam int MW = FW + 4;
    localparam int SW = $clog2(MW + 1);
    localparam int EMAX = (1 << EW) - 1;

    typedef enum logic [2:0] {
        GET_AB,
        UNPACK,
        ALIGN,
        ADD_SUB,
        NORMALIZE,
        ROUND,
        PACK,
        PUT_Z
    } state_t;

    state_t state;
    fp64_t  a_in;
    fp64_t  b_in;
    logic   a_got;
    logic   b_got;

    logic            a_s;
    logic            b_s;
    logic            z_s;
    logic [EW-1:0]   a_e;
    logic [EW-1:0]   b_e;
    logic [MW-1:0]   a_m;
    logic [MW-1:0]   b_m;
    // two spare bits so carry and underflow stay visible
    logic signed [EW+1:0] z_e;
    logic [MW:0]     z_m;
    logic            z_zero;

    logic            a_big;
    logic [EW-1:0]   e_diff;
    logic [SW-1:0]   shift;
    logic [MW-1:0]   small_m;
    logic [2*MW-1:0] small_ext;
    logic [MW-1:0]   small_aligned;
    logic            mag_zero;
    logic            round_up;
    logic [FW+1:0]   rounded;

    always_comb begin
        a_big = (a_e >= b_e);
        e_diff = a_big ? (a_e - b_e) : (b_e - a_e);
        // beyond MW places only the sticky bit survives
        shift = (e_diff > EW'(MW)) ? SW'(MW) : e_diff[SW-1:0];
        small_m = a_big ? b_m : a_m;
        small_ext = {small_m, {MW{1'b0}}} >> shift;
        small_aligned = {small_ext[2*MW-1:MW+1], small_ext[MW] | (|small_ext[MW-1:0])};
        // exact cancellation, or both operands zero
        mag_zero = (a_m == b_m) && ((a_s != b_s) || (a_m == '0));
        // round half to even on guard, round, sticky and lsb
        round_up = z_m[2] & (z_m[1] | z_m[0] | z_m[3]);
        rounded = {1'b0, z_m[MW-1:3]} + (FW+2)'(round_up);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= GET_AB;
            a_got <= 1'b0;
            b_got <= 1'b0;
            input_a_ack <= 1'b0;
            input_b_ack <= 1'b0;
            output_z_stb <= 1'b0;
        end else begin
            input_a_ack <= 1'b0;
            input_b_ack <= 1'b0;
            case (state)
                GET_AB: begin
                    // operands may arrive in either order or together
                    if (input_a_stb && !a_got) begin
                        a_in <= input_a;
                        a_got <= 1'b1;
                        input_a_ack <= 1'b1;
                    end
                    if (input_b_stb && !b_got) begin
                        b_in <= input_b;
                        b_got <= 1'b1;
                        input_b_ack <= 1'b1;
                    end
                    if ((a_got || input_a_stb) && (b_got || input_b_stb)) begin
                        a_got <= 1'b0;
                        b_got <= 1'b0;
                        state <= UNPACK;
                    end
                end
                UNPACK: begin
                    a_s <= a_in.f.sign;
                    b_s <= b_in.f.sign;
                    a_e <= a_in.f.exp;
                    b_e <= b_in.f.exp;
                    // a zero exponent is zero or subnormal, both become zero
                    a_m <= (a_in.f.exp == '0) ? '0 : {1'b1, a_in.f.frac, 3'b000};
                    b_m <= (b_in.f.exp == '0) ? '0 : {1'b1, b_in.f.frac, 3'b000};
                    state <= ALIGN;
                end
                ALIGN: begin
                    if (a_big) begin
                        b_m <= small_aligned;
                        z_e <= $signed({2'b00, a_e});
                    end else begin
                        a_m <= small_aligned;
                        z_e <= $signed({2'b00, b_e});
                    end
                    state <= ADD_SUB;
                end
                ADD_SUB: begin
                    z_zero <= mag_zero;
                    if (mag_zero) begin
                        // x - x is +0, -0 + -0 stays -0
                        z_s <= a_s & b_s;
                        state <= PACK;
                    end else begin
                        state <= NORMALIZE;
                        if (a_s == b_s) begin
                            z_m <= {1'b0, a_m} + {1'b0, b_m};
                            z_s <= a_s;
                        end else if (a_m > b_m) begin
                            z_m <= {1'b0, a_m - b_m};
                            z_s <= a_s;
                        end else begin
                            z_m <= {1'b0, b_m - a_m};
                            z_s <= b_s;
                        end
                    end
                end
                NORMALIZE: begin
                    if (z_m[MW]) begin
                        // carry out, one step right with the lost bit kept in sticky
                        z_m <= {1'b0, z_m[MW:2], z_m[1] | z_m[0]};
                        z_e <= z_e + 1;
                        state <= ROUND;
                    end else if (z_m[MW-1]) begin
                        state <= ROUND;
                    end else begin
                        z_m <= z_m << 1;
                        z_e <= z_e - 1;
                    end
                end
                ROUND: begin
                    if (rounded[FW+1]) begin
                        // mantissa rolled over to 2.0
                        z_m[MW-1:3] <= rounded[FW+1:1];
                        z_e <= z_e + 1;
                    end else begin
                        z_m[MW-1:3] <= rounded[FW:0];
                    end
                    state <= PACK;
                end
                PACK: begin
                    output_z.f.sign <= z_s;
                    if (z_zero || z_e <= 0) begin
                        output_z.f.exp <= '0;
                        output_z.f.frac <= '0;
                    end else if (z_e >= EMAX) begin
                        // overflow saturates to infinity
                        output_z.f.exp <= '1;
                        output_z.f.frac <= '0;
                    end else begin
                        output_z.f.exp <= z_e[EW-1:0];
                        output_z.f.frac <= z_m[MW-2:3];
                    end
                    output_z_stb <= 1'b1;
                    state <= PUT_Z;
                end
                PUT_Z: begin
                    // result stays put until the consumer takes it
                    if (output_z_ack) begin
                        output_z_stb <= 1'b0;
                        state <= GET_AB;
                    end
                end
                default: state <= GET_AB;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/vec_add_ctrl.sv */
// start is sampled only while idle; a start during a running operation is dropped, done is one cycle
`default_nettype none

module vec_add_ctrl
    import vec_add_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       start,
    input  wire fp_vec_t    a,
    input  wire fp_vec_t    b,
    output fp_vec_t         c,
    output logic            done,
    output fp_vec_t         lane_a,
    output fp_vec_t         lane_b,
    output lane_mask_t      a_stb,
    output lane_mask_t      b_stb,
    input  wire lane_mask_t a_ack,
    input  wire lane_mask_t b_ack,
    input  wire fp_vec_t    lane_z,
    input  wire lane_mask_t z_stb,
    output lane_mask_t      z_ack
);

    typedef enum logic {
        IDLE,
        BUSY
    } state_t;

    state_t     state;
    // lanes whose result has been recorded in this operation
    lane_mask_t seen;
    lane_mask_t seen_next;

    assign seen_next = seen | z_stb;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            seen <= '0;
            a_stb <= '0;
            b_stb <= '0;
            z_ack <= '0;
            done <= 1'b0;
            c <= '0;
        end else begin
            done <= 1'b0;
            // ack a lane once, in the cycle after it is first seen
            z_ack <= (state == BUSY) ? (z_stb & ~seen) : '0;
            case (state)
                IDLE: begin
                    if (start) begin
                        lane_a <= a;
                        lane_b <= b;
                        a_stb <= '1;
                        b_stb <= '1;
                        seen <= '0;
                        state <= BUSY;
                    end
                end
                BUSY: begin
                    // each strobe drops lane by lane as its ack comes back
                    a_stb <= a_stb & ~a_ack;
                    b_stb <= b_stb & ~b_ack;
                    seen <= seen_next;
                    // early lanes hold their result until acked, so lane_z is valid here
                    if (&seen_next) begin
                        c <= lane_z;
                        done <= 1'b1;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/vec_add_top.sv */
// lane count set by VEC_LANES at compile time; no output back-pressure, c holds until the next done
`default_nettype none

`include "vec_add_params.svh"

module vec_add_top
    import vec_add_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    start,
    input  wire fp_vec_t a,
    input  wire fp_vec_t b,
    output fp_vec_t      c,
    output logic         done
);

    fp_vec_t    lane_a;
    fp_vec_t    lane_b;
    fp_vec_t    lane_z;
    lane_mask_t a_stb;
    lane_mask_t b_stb;
    lane_mask_t a_ack;
    lane_mask_t b_ack;
    lane_mask_t z_stb;
    lane_mask_t z_ack;

    vec_add_ctrl ctrl_i (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .a      (a),
        .b      (b),
        .c      (c),
        .done   (done),
        .lane_a (lane_a),
        .lane_b (lane_b),
        .a_stb  (a_stb),
        .b_stb  (b_stb),
        .a_ack  (a_ack),
        .b_ack  (b_ack),
        .lane_z (lane_z),
        .z_stb  (z_stb),
        .z_ack  (z_ack)
    );

    // one independent adder per lane
    for (genvar i = 0; i < `VEC_LANES; i++) begin : g_lane
        double_adder adder_i (
            .clk          (clk),
            .rst          (rst),
            .input_a      (lane_a[i]),
            .input_b      (lane_b[i]),
            .input_a_stb  (a_stb[i]),
            .input_b_stb  (b_stb[i]),
            .input_a_ack  (a_ack[i]),
            .input_b_ack  (b_ack[i]),
            .output_z     (lane_z[i]),
            .output_z_stb (z_stb[i]),
            .output_z_ack (z_ack[i])
        );
    end

endmodule

`default_nettype wire

/* verification/vec_add_sva.sv */
// bound to vec_add_ctrl; sampled on the rising clock, handshake rules are checked outside reset
`default_nettype none

module vec_add_sva
    import vec_add_pkg::*;
(
    input wire logic       clk,
    input wire logic       rst,
    input wire logic       start,
    input wire logic       done,
    input wire lane_mask_t a_stb,
    input wire lane_mask_t b_stb,
    input wire lane_mask_t a_ack,
    input wire lane_mask_t b_ack,
    input wire lane_mask_t z_stb,
    input wire lane_mask_t z_ack
);

    timeunit 1ns;
    timeprecision 1ps;

    // number of failed assertions so far
    int fail_count = 0;

    done_low_in_reset: assert property (@(posedge clk) rst |=> !done)
        else begin
            $error("done high after a reset cycle");
            fail_count++;
        end

    done_one_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            $error("done held longer than one cycle");
            fail_count++;
        end

    // a lane is acked only while it still offers its result
    z_ack_with_z_stb: assert property (@(posedge clk) disable iff (rst)
        (z_ack & ~z_stb) == '0)
        else begin
            $error("z_ack while the lane offers no result");
            fail_count++;
        end

    a_stb_drops_after_ack: assert property (@(posedge clk) disable iff (rst)
        (|a_ack) |=> ((a_stb & $past(a_ack)) == '0))
        else begin
            $error("a_stb still high after its ack");
            fail_count++;
        end

    b_stb_drops_after_ack: assert property (@(posedge clk) disable iff (rst)
        (|b_ack) |=> ((b_stb & $past(b_ack)) == '0))
        else begin
            $error("b_stb still high after its ack");
            fail_count++;
        end

    operand_stb_needs_start: assert property (@(posedge clk) disable iff (rst)
        (|(a_stb & ~$past(a_stb))) |-> $past(start))
        else begin
            $error("operand strobe raised without a start");
            fail_count++;
        end

endmodule

`default_nettype wire

/* verification/vec_add_tb.sv */
// expected sums come from real arithmetic, so every operand and every sum must stay a normal number
`default_nettype none

`include "vec_add_params.svh"

module vec_add_tb
    import vec_add_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_CASES = 5;
    localparam int NUM_RANDOM = 6;
    localparam int TIMEOUT = 500;

    logic    clk;
    logic    rst;
    logic    start;
    fp_vec_t a;
    fp_vec_t b;
    fp_vec_t c;
    logic    done;

    string   case_name [NUM_CASES];
    fp_vec_t case_a [NUM_CASES];
    fp_vec_t case_b [NUM_CASES];
    integer  seed;
    fp_vec_t va;
    fp_vec_t vb;

    vec_add_top dut_i (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .a     (a),
        .b     (b),
        .c     (c),
        .done  (done)
    );

    bind vec_add_ctrl vec_add_sva sva_i (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .done  (done),
        .a_stb (a_stb),
        .b_stb (b_stb),
        .a_ack (a_ack),
        .b_ack (b_ack),
        .z_stb (z_stb),
        .z_ack (z_ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    always @(negedge clk) begin
        if (dut_i.ctrl_i.sva_i.fail_count != 0) begin
            abort_run("a bound assertion on the controller handshake failed");
        end
    end

    task automatic check_lane(input string name, input int lane,
                              input fp64_t expected, input fp64_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH %s lane %0d expected %h actual %h",
                                name, lane, expected.raw, actual.raw));
        end
    endtask

    task automatic check_done(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH %s done expected %b actual %b",
                                name, expected, actual));
        end
    endtask

    // the four values repeat across lanes when VEC_LANES is larger
    function automatic fp_vec_t make_vec(input real r0, input real r1,
                                         input real r2, input real r3);
        fp_vec_t v;
        real     r [4];
        r = '{r0, r1, r2, r3};
        for (int i = 0; i < `VEC_LANES; i++) begin
            v[i].raw = $realtobits(r[i % 4]);
        end
        return v;
    endfunction

    // host doubles round to nearest even, the same rule the adder follows
    function automatic fp_vec_t expected_sum(input fp_vec_t x, input fp_vec_t y);
        fp_vec_t s;
        for (int i = 0; i < `VEC_LANES; i++) begin
            s[i].raw = $realtobits($bitstoreal(x[i].raw) + $bitstoreal(y[i].raw));
        end
        return s;
    endfunction

    function automatic fp64_t rand_fp();
        fp64_t r;
        r.f.sign = 1'($random(seed));
        r.f.exp = `FP_EXP_W'(900 + ($unsigned($random(seed)) % 201));
        r.f.frac = `FP_FRAC_W'({$random(seed), $random(seed)});
        return r;
    endfunction

    task automatic load_table();
        case_name[0] = "same_sign";
        case_a[0] = make_vec(1.0, 3.5, 100.0, 1.5);
        case_b[0] = make_vec(2.0, 0.25, 28.0, 1.5);
        case_name[1] = "mixed_sign";
        case_a[1] = make_vec(5.0, -2.5, 1.0, 1.0e10);
        case_b[1] = make_vec(-3.0, 1.0, -0.375, -1.0);
        case_name[2] = "cancel_normalize";
        case_a[2] = make_vec(3.75, 1.0000001, 0.0, -0.0);
        case_b[2] = make_vec(-3.75, -1.0, 3.25, -0.0);
        // 2^-53 and 1.5 * 2^-53 against values near 1.0
        case_name[3] = "round_even";
        case_a[3] = make_vec(1.0, $bitstoreal(64'h3FF0_0000_0000_0001), 1.0, -1.0);
        case_b[3] = make_vec($bitstoreal(64'h3CA0_0000_0000_0000),
                             $bitstoreal(64'h3CA0_0000_0000_0000),
                             $bitstoreal(64'h3CA8_0000_0000_0000),
                             $bitstoreal(64'hBCA0_0000_0000_0000));
        // 2^-60 is far below half an ulp of 1.0
        case_name[4] = "wide_gap";
        case_a[4] = make_vec(1.0, 1.0e20, -1.0, $bitstoreal(64'h3C30_0000_0000_0000));
        case_b[4] = make_vec($bitstoreal(64'h3C30_0000_0000_0000), 1.0,
                             $bitstoreal(64'h3C30_0000_0000_0000), 3.0);
    endtask

    task automatic pulse_start(input fp_vec_t x, input fp_vec_t y);
        @(negedge clk);
        a = x;
        b = y;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_done(input string name);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!done && n < TIMEOUT);
        if (!done) begin
            abort_run($sformatf("%s: no done within %0d cycles", name, TIMEOUT));
        end
    endtask

    task automatic check_vector(input string name, input fp_vec_t x, input fp_vec_t y);
        fp_vec_t s;
        s = expected_sum(x, y);
        for (int i = 0; i < `VEC_LANES; i++) begin
            check_lane(name, i, s[i], c[i]);
        end
    endtask

    task automatic run_case(input string name, input fp_vec_t x, input fp_vec_t y);
        pulse_start(x, y);
        wait_done(name);
        check_vector(name, x, y);
        @(negedge clk);
        check_done(name, 1'b0, done);
    endtask

    initial begin
        seed = 32'h12c7_2306;
        rst = 1'b1;
        start = 1'b0;
        a = '0;
        b = '0;
        load_table();
        repeat (10) @(negedge clk);
        rst = 1'b0;

        repeat (20) begin
            @(negedge clk);
            check_done("idle_after_reset", 1'b0, done);
        end

        for (int k = 0; k < NUM_CASES; k++) begin
            run_case(case_name[k], case_a[k], case_b[k]);
        end

        for (int k = 0; k < NUM_RANDOM; k++) begin
            for (int i = 0; i < `VEC_LANES; i++) begin
                va[i] = rand_fp();
                vb[i] = rand_fp();
            end
            run_case($sformatf("random_%0d", k), va, vb);
        end

        // second start lands while the lanes are still busy
        va = make_vec(1.25, -4.0, 6.5, 1.0e3);
        vb = make_vec(2.5, 1.0, -0.5, 24.0);
        pulse_start(va, vb);
        @(negedge clk);
        pulse_start(vb, vb);
        wait_done("double_start");
        check_vector("double_start", va, vb);
        repeat (40) begin
            @(negedge clk);
            check_done("double_start", 1'b0, done);
            check_vector("hold_c", va, vb);
        end

        if (dut_i.ctrl_i.sva_i.fail_count != 0) begin
            abort_run("a bound assertion on the controller handshake failed");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+common
common/vec_add_pkg.sv
double_adder/double_adder.sv
rtl/vec_add_ctrl.sv
rtl/vec_add_top.sv
verification/vec_add_sva.sv
verification/vec_add_tb.sv
